// File: dcache_top.f
hdl/dcache_pkg.sv
hdl/dcache_ram.sv
hdl/dcache_tag_lookup.sv
hdl/dcache_ctrl.sv
hdl/dcache_data_path.sv
hdl/dcache_top.sv
testbench/tb_dcache.sv

// File: run.sh
#!/bin/sh
# Builds the data cache testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --top-module tb_dcache -o tb_dcache -f dcache_top.f \
   || { echo "Verilator build failed"; exit 1; }
./obj_dir/tb_dcache > sim.log 2>&1
cat sim.log
grep -q "TEST RESULT: FAIL" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "TEST RESULT: PASS" sim.log || { echo "Simulation ended without a result"; exit 1; }
echo "Simulation passed"

// File: testbench/tb_dcache.sv
/* Random-stimulus testbench for the direct-mapped data cache.
   Runs reads, writes and invalidates against a cache model and a backing memory. */
`timescale 1ns/100ps

module tb_dcache;
   import dcache_pkg::*;

   // Geometry handed to the DUT
   localparam int SET_WIDTH       = 6;
   localparam int BLOCK_WIDTH     = 4;
   localparam int LINE_WORDS      = 1 << (BLOCK_WIDTH - 2);
   localparam int NUM_SETS        = 1 << SET_WIDTH;
   localparam int NUM_OPS         = 400;
   localparam int TIMEOUT_CYCLES  = NUM_OPS * 40;
   // Hit, write and invalidate answer on the second sampled cycle
   localparam int FAST_ACK_CYCLES = 2;

   logic     clk = 1'b0;
   logic     rst;
   cpu_req_t cpu_req;
   logic     cpu_ack;
   word_t    cpu_dat;
   logic     refill_req;
   adr_t     refill_adr;
   refill_t  refill;
   logic     inv_stb;
   adr_t     inv_adr;
   logic     inv_ack;

   // Cache model with one line per set
   logic        model_valid [NUM_SETS];
   logic [31:0] model_tag   [NUM_SETS];
   word_t       model_line  [NUM_SETS][LINE_WORDS];

   logic [31:0] rng_state = 32'heffc5a49;
   int          bus_word_idx = 0;
   int          cycle_cnt = 0;
   int          num_read_hits = 0;
   int          num_read_misses = 0;
   int          num_writes = 0;
   int          num_invs = 0;

   dcache_top #(
      .SET_WIDTH  (SET_WIDTH),
      .BLOCK_WIDTH(BLOCK_WIDTH)
   ) dcache_top_inst (
      .clk         (clk),
      .rst         (rst),
      .cpu_req_i   (cpu_req),
      .cpu_ack_o   (cpu_ack),
      .cpu_dat_o   (cpu_dat),
      .refill_req_o(refill_req),
      .refill_adr_o(refill_adr),
      .refill_i    (refill),
      .inv_stb_i   (inv_stb),
      .inv_adr_i   (inv_adr),
      .inv_ack_o   (inv_ack)
   );

   // 100 ns clock
   always #50 clk = ~clk;

   // Run limit in cycles
   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= TIMEOUT_CYCLES) begin
         $display("Timeout after %0d cycles, the cache stopped answering", cycle_cnt);
         $display("TEST RESULT: FAIL");
         $fatal(1, "Simulation timeout");
      end
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   task automatic next_rand(output logic [31:0] r);
      rng_state = xorshift32(rng_state);
      r = rng_state;
   endtask

   // Memory behind the cache where every address bit feeds the word
   function automatic word_t backing_word(input adr_t adr);
      return (adr * 32'h9e3779b1) ^ {adr[15:0], adr[31:16]};
   endfunction

   function automatic adr_t line_base(input adr_t adr);
      return {adr[31:BLOCK_WIDTH], {BLOCK_WIDTH{1'b0}}};
   endfunction

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp) begin
         $display("Mismatch on %s: got %h, expected %h", name, got, exp);
         $display("TEST RESULT: FAIL");
         $fatal(1, "Check failed");
      end
   endtask

   // Bus side of a refill with one word per strobe and random gaps
   task automatic drive_bus();
      logic [31:0] r;
      if (refill_req) begin
         // Strobe of the last cycle was taken by the cache
         if (refill.stb) begin
            bus_word_idx = bus_word_idx + 1;
         end
         next_rand(r);
         refill.stb = (r[1:0] != 2'b00);
         refill.dat = backing_word(refill_adr + adr_t'(bus_word_idx * 4));
      end else begin
         bus_word_idx = 0;
         refill       = '0;
      end
   endtask

   // Inputs change 10 ns after the rising edge
   task automatic next_cycle();
      @(posedge clk);
      #10;
      drive_bus();
   endtask

   task automatic check_quiet();
      @(negedge clk);
      check_value("cpu_ack_o", 32'(cpu_ack), 32'h0);
      check_value("refill_req_o", 32'(refill_req), 32'h0);
      check_value("inv_ack_o", 32'(inv_ack), 32'h0);
   endtask

   // Holds one request until the ack pulse
   task automatic cpu_access(input logic we, input adr_t adr, input word_t dat,
                             input bsel_t bsel, output word_t rdat,
                             output logic refilled, output int cycles);
      logic got_ack;
      refilled = 1'b0;
      cycles   = 0;
      got_ack  = 1'b0;
      next_cycle();
      cpu_req.valid = 1'b1;
      cpu_req.we    = we;
      cpu_req.adr   = adr;
      cpu_req.dat   = dat;
      cpu_req.bsel  = bsel;
      while (!got_ack) begin
         @(negedge clk);
         cycles++;
         check_value("inv_ack_o", 32'(inv_ack), 32'h0);
         if (refill_req) begin
            refilled = 1'b1;
            check_value("refill_adr_o", refill_adr, line_base(adr));
         end
         got_ack = cpu_ack;
         if (!got_ack) begin
            next_cycle();
         end
      end
      rdat = cpu_dat;
      next_cycle();
      cpu_req = '0;
      // Ack lasts a single cycle
      check_quiet();
   endtask

   task automatic do_read(input adr_t adr);
      int    idx;
      int    word;
      logic  hit;
      word_t rdat;
      logic  refilled;
      int    cycles;
      idx  = int'(adr[SET_WIDTH+BLOCK_WIDTH-1:BLOCK_WIDTH]);
      word = int'(adr[BLOCK_WIDTH-1:2]);
      hit  = model_valid[idx] && (model_tag[idx] == 32'(adr[31:SET_WIDTH+BLOCK_WIDTH]));
      cpu_access(1'b0, adr, '0, '0, rdat, refilled, cycles);
      check_value("refill_req_o seen", 32'(refilled), 32'(!hit));
      if (hit) begin
         check_value("cpu_ack_o latency", cycles, FAST_ACK_CYCLES);
         num_read_hits++;
      end else begin
         // Missed line now holds the backing words
         model_valid[idx] = 1'b1;
         model_tag[idx]   = 32'(adr[31:SET_WIDTH+BLOCK_WIDTH]);
         for (int k = 0; k < LINE_WORDS; k++) begin
            model_line[idx][k] = backing_word(line_base(adr) + adr_t'(k * 4));
         end
         num_read_misses++;
      end
      check_value("cpu_dat_o", rdat, model_line[idx][word]);
   endtask

   task automatic do_write(input adr_t adr, input word_t dat, input bsel_t bsel);
      int    idx;
      int    word;
      logic  hit;
      word_t rdat;
      word_t merged;
      logic  refilled;
      int    cycles;
      idx  = int'(adr[SET_WIDTH+BLOCK_WIDTH-1:BLOCK_WIDTH]);
      word = int'(adr[BLOCK_WIDTH-1:2]);
      hit  = model_valid[idx] && (model_tag[idx] == 32'(adr[31:SET_WIDTH+BLOCK_WIDTH]));
      cpu_access(1'b1, adr, dat, bsel, rdat, refilled, cycles);
      // Writes never refill on a hit or a miss
      check_value("refill_req_o seen", 32'(refilled), 32'h0);
      check_value("cpu_ack_o latency", cycles, FAST_ACK_CYCLES);
      if (hit) begin
         merged = model_line[idx][word];
         for (int b = 0; b < 4; b++) begin
            if (bsel[b]) begin
               merged[8*b +: 8] = dat[8*b +: 8];
            end
         end
         model_line[idx][word] = merged;
      end
      num_writes++;
   endtask

   task automatic do_invalidate(input adr_t adr);
      int   cycles;
      logic got_ack;
      cycles  = 0;
      got_ack = 1'b0;
      next_cycle();
      inv_stb = 1'b1;
      inv_adr = adr;
      while (!got_ack) begin
         @(negedge clk);
         cycles++;
         check_value("cpu_ack_o", 32'(cpu_ack), 32'h0);
         check_value("refill_req_o", 32'(refill_req), 32'h0);
         got_ack = inv_ack;
         if (!got_ack) begin
            next_cycle();
         end
      end
      check_value("inv_ack_o latency", cycles, FAST_ACK_CYCLES);
      next_cycle();
      inv_stb = 1'b0;
      inv_adr = '0;
      // Invalidate ack lasts a single cycle
      check_quiet();
      model_valid[int'(adr[SET_WIDTH+BLOCK_WIDTH-1:BLOCK_WIDTH])] = 1'b0;
      num_invs++;
   endtask

   // Window of 4 tags over 8 sets so that hits and conflicts both occur
   task automatic random_adr(output adr_t adr);
      logic [31:0] r;
      next_rand(r);
      adr          = '0;
      adr[31:28]   = 4'ha;
      adr[BLOCK_WIDTH-1:2] = r[1:0];
      adr[BLOCK_WIDTH+2:BLOCK_WIDTH] = r[4:2];
      adr[SET_WIDTH+BLOCK_WIDTH+1:SET_WIDTH+BLOCK_WIDTH] = r[6:5];
   endtask

   initial begin
      logic [31:0] r;
      logic [31:0] dat;
      adr_t        adr;
      rst     = 1'b1;
      cpu_req = '0;
      refill  = '0;
      inv_stb = 1'b0;
      inv_adr = '0;
      for (int s = 0; s < NUM_SETS; s++) begin
         model_valid[s] = 1'b0;
         model_tag[s]   = '0;
      end
      // Outputs stay low through the four reset edges
      repeat (3) check_quiet();
      @(posedge clk);
      #10;
      rst = 1'b0;
      repeat (2) check_quiet();
      // First access is a read that waits out the clear sweep and misses
      for (int i = 0; i < NUM_OPS; i++) begin
         next_rand(r);
         random_adr(adr);
         if ((i == 0) || (r[3:0] < 4'd8)) begin
            do_read(adr);
         end else if (r[3:0] < 4'd14) begin
            next_rand(dat);
            do_write(adr, dat, r[7:4]);
         end else begin
            do_invalidate(adr);
         end
      end
      $display("Read hits %0d, read misses %0d, writes %0d, invalidates %0d",
               num_read_hits, num_read_misses, num_writes, num_invs);
      $display("TEST RESULT: PASS");
      $finish;
   end

endmodule

// File: hdl/dcache_top.sv
/* Direct-mapped data cache top level for the load/store unit.
   Sets the cache geometry and connects lookup, controller and data path. */
`timescale 1ns/100ps

module dcache_top #(
   // 64 sets of 16-byte lines by default
   parameter int SET_WIDTH   = 6,
   parameter int BLOCK_WIDTH = 4
) (
   input  logic                 clk,
   input  logic                 rst,
   input  dcache_pkg::cpu_req_t cpu_req_i,
   output logic                 cpu_ack_o,
   output dcache_pkg::word_t    cpu_dat_o,
   output logic                 refill_req_o,
   output dcache_pkg::adr_t     refill_adr_o,
   input  dcache_pkg::refill_t  refill_i,
   input  logic                 inv_stb_i,
   input  dcache_pkg::adr_t     inv_adr_i,
   output logic                 inv_ack_o
);
   import dcache_pkg::*;

   logic                   hit;
   logic                   sweep_done;
   logic                   tag_we;
   logic                   tag_valid;
   adr_t                   tag_wr_adr;
   logic                   data_we;
   logic                   refill_sel;
   logic [BLOCK_WIDTH-3:0] refill_word;

   // Decode, tag lookup
   dcache_tag_lookup #(
      .SET_WIDTH  (SET_WIDTH),
      .BLOCK_WIDTH(BLOCK_WIDTH)
   ) dcache_tag_lookup_inst (
      .clk         (clk),
      .rst         (rst),
      .req_adr_i   (cpu_req_i.adr),
      .wr_adr_i    (tag_wr_adr),
      .tag_we_i    (tag_we),
      .tag_valid_i (tag_valid),
      .hit_o       (hit),
      .sweep_done_o(sweep_done)
   );

   // Execute, controller FSM
   dcache_ctrl #(
      .SET_WIDTH  (SET_WIDTH),
      .BLOCK_WIDTH(BLOCK_WIDTH)
   ) dcache_ctrl_inst (
      .clk          (clk),
      .rst          (rst),
      .req_i        (cpu_req_i),
      .refill_i     (refill_i),
      .inv_stb_i    (inv_stb_i),
      .inv_adr_i    (inv_adr_i),
      .hit_i        (hit),
      .sweep_done_i (sweep_done),
      .ack_o        (cpu_ack_o),
      .refill_req_o (refill_req_o),
      .refill_adr_o (refill_adr_o),
      .inv_ack_o    (inv_ack_o),
      .tag_we_o     (tag_we),
      .tag_valid_o  (tag_valid),
      .tag_wr_adr_o (tag_wr_adr),
      .data_we_o    (data_we),
      .refill_sel_o (refill_sel),
      .refill_word_o(refill_word)
   );

   // Result, data store and read word
   dcache_data_path #(
      .SET_WIDTH  (SET_WIDTH),
      .BLOCK_WIDTH(BLOCK_WIDTH)
   ) dcache_data_path_inst (
      .clk          (clk),
      .req_i        (cpu_req_i),
      .refill_i     (refill_i),
      .data_we_i    (data_we),
      .refill_sel_i (refill_sel),
      .refill_word_i(refill_word),
      .rd_dat_o     (cpu_dat_o)
   );

endmodule

// File: hdl/dcache_data_path.sv
/* Data store of the cache with byte-select write merge and read data.
   Written by CPU write hits and by refill words from the bus. */
`timescale 1ns/100ps

module dcache_data_path #(
   parameter int SET_WIDTH   = 6,
   parameter int BLOCK_WIDTH = 4
) (
   input  logic                   clk,
   input  dcache_pkg::cpu_req_t   req_i,
   input  dcache_pkg::refill_t    refill_i,
   input  logic                   data_we_i,
   input  logic                   refill_sel_i,
   input  logic [BLOCK_WIDTH-3:0] refill_word_i,
   output dcache_pkg::word_t      rd_dat_o
);
   import dcache_pkg::*;

   // Word address over all sets, index above word offset
   localparam int WADR_WIDTH = SET_WIDTH + BLOCK_WIDTH - 2;

   logic [WADR_WIDTH-1:0] req_wadr;
   logic [WADR_WIDTH-1:0] refill_wadr;
   logic [WADR_WIDTH-1:0] ram_waddr;
   word_t                 merged_dat;
   word_t                 ram_din;

   assign req_wadr = req_i.adr[SET_WIDTH+BLOCK_WIDTH-1:2];

   // Refill word within the request's line
   assign refill_wadr = {req_i.adr[SET_WIDTH+BLOCK_WIDTH-1:BLOCK_WIDTH], refill_word_i};

   // Byte merge against the stored word read in the IDLE cycle
   always_comb begin
      for (int i = 0; i < BSEL_WIDTH; i++) begin
         if (req_i.bsel[i]) begin
            merged_dat[8*i +: 8] = req_i.dat[8*i +: 8];
         end else begin
            merged_dat[8*i +: 8] = rd_dat_o[8*i +: 8];
         end
      end
   end

   // Bus word during refill, merged CPU word otherwise
   assign ram_waddr = refill_sel_i ? refill_wadr : req_wadr;
   assign ram_din   = refill_sel_i ? refill_i.dat : merged_dat;

   dcache_ram #(
      .ADDR_WIDTH(WADR_WIDTH),
      .DATA_WIDTH(WORD_WIDTH)
   ) data_ram_inst (
      .clk    (clk),
      .raddr_i(req_wadr),
      .waddr_i(ram_waddr),
      .we_i   (data_we_i),
      .din_i  (ram_din),
      .dout_o (rd_dat_o)
   );

endmodule

// File: hdl/dcache_ctrl.sv
/* Controller FSM of the data cache for lookup, write, refill and invalidate.
   Drives the tag and data write strobes and counts the refill words. */
`timescale 1ns/100ps

module dcache_ctrl #(
   parameter int SET_WIDTH   = 6,
   parameter int BLOCK_WIDTH = 4
) (
   input  logic                   clk,
   input  logic                   rst,
   input  dcache_pkg::cpu_req_t   req_i,
   input  dcache_pkg::refill_t    refill_i,
   input  logic                   inv_stb_i,
   input  dcache_pkg::adr_t       inv_adr_i,
   input  logic                   hit_i,
   input  logic                   sweep_done_i,
   output logic                   ack_o,
   output logic                   refill_req_o,
   output dcache_pkg::adr_t       refill_adr_o,
   output logic                   inv_ack_o,
   output logic                   tag_we_o,
   output logic                   tag_valid_o,
   output dcache_pkg::adr_t       tag_wr_adr_o,
   output logic                   data_we_o,
   output logic                   refill_sel_o,
   output logic [BLOCK_WIDTH-3:0] refill_word_o
);
   import dcache_pkg::*;

   localparam int TAG_WIDTH      = ADR_WIDTH - SET_WIDTH - BLOCK_WIDTH;
   // Tag plus index, the part of the address naming a line
   localparam int LINE_ADR_WIDTH = TAG_WIDTH + SET_WIDTH;

   ctrl_state_e            state_q;
   ctrl_state_e            state_d;
   logic [BLOCK_WIDTH-3:0] refill_cnt_q;
   logic                   refill_first;
   logic                   refill_last;

   assign refill_first = (refill_cnt_q == '0);
   assign refill_last  = &refill_cnt_q;

   always_ff @(posedge clk) begin
      if (rst) begin
         state_q      <= IDLE;
         refill_cnt_q <= '0;
      end else begin
         state_q <= state_d;
         // Counter restarts at the line base on every miss
         if (state_q == LOOKUP) begin
            refill_cnt_q <= '0;
         end else if ((state_q == REFILL) && refill_i.stb) begin
            refill_cnt_q <= refill_cnt_q + 1'b1;
         end
      end
   end

   always_comb begin
      state_d     = state_q;
      ack_o       = 1'b0;
      inv_ack_o   = 1'b0;
      tag_we_o    = 1'b0;
      tag_valid_o = 1'b0;
      data_we_o   = 1'b0;
      case (state_q)
         IDLE: begin
            // Nothing accepted until the valid bits are cleared
            if (sweep_done_i) begin
               // Invalidate goes ahead of a waiting request
               if (inv_stb_i) begin
                  state_d = INVALIDATE;
               end else if (req_i.valid) begin
                  state_d = LOOKUP;
               end
            end
         end
         LOOKUP: begin
            if (req_i.we) begin
               // Write miss leaves the cache as it is
               ack_o     = 1'b1;
               data_we_o = hit_i;
               state_d   = IDLE;
            end else if (hit_i) begin
               ack_o   = 1'b1;
               state_d = IDLE;
            end else begin
               state_d = REFILL;
            end
         end
         REFILL: begin
            if (refill_i.stb) begin
               data_we_o = 1'b1;
               // First word drops the old entry so a partial line never hits
               if (refill_first) begin
                  tag_we_o    = 1'b1;
                  tag_valid_o = 1'b0;
               end
               // Last word installs the new tag as valid
               if (refill_last) begin
                  tag_we_o    = 1'b1;
                  tag_valid_o = 1'b1;
                  state_d     = IDLE;
               end
            end
         end
         INVALIDATE: begin
            tag_we_o    = 1'b1;
            tag_valid_o = 1'b0;
            inv_ack_o   = 1'b1;
            state_d     = IDLE;
         end
         default: begin
            state_d = IDLE;
         end
      endcase
   end

   assign refill_req_o = (state_q == REFILL);
   assign refill_sel_o = (state_q == REFILL);
   assign refill_word_o = refill_cnt_q;

   // Line base of the missed request
   assign refill_adr_o = {req_i.adr[ADR_WIDTH-1 -: LINE_ADR_WIDTH], {BLOCK_WIDTH{1'b0}}};

   // Invalidate address only in INVALIDATE, request address for refill writes
   assign tag_wr_adr_o = (state_q == INVALIDATE) ? inv_adr_i : req_i.adr;

endmodule

// File: hdl/dcache_tag_lookup.sv
/* Tag store and hit compare of the data cache.
   Clears every valid bit after reset, then writes entries for the controller. */
`timescale 1ns/100ps

module dcache_tag_lookup #(
   parameter int SET_WIDTH   = 6,
   parameter int BLOCK_WIDTH = 4
) (
   input  logic             clk,
   input  logic             rst,
   input  dcache_pkg::adr_t req_adr_i,
   input  dcache_pkg::adr_t wr_adr_i,
   input  logic             tag_we_i,
   input  logic             tag_valid_i,
   output logic             hit_o,
   output logic             sweep_done_o
);
   import dcache_pkg::*;

   localparam int TAG_WIDTH = ADR_WIDTH - SET_WIDTH - BLOCK_WIDTH;
   // Bit positions of index and tag in a byte address
   localparam int IDX_LSB   = BLOCK_WIDTH;
   localparam int TAG_LSB   = BLOCK_WIDTH + SET_WIDTH;

   // Entry is the valid bit on top of the tag
   logic [TAG_WIDTH:0]   ram_din;
   logic [TAG_WIDTH:0]   ram_dout;
   logic [SET_WIDTH-1:0] ram_waddr;
   logic                 ram_we;
   logic [SET_WIDTH-1:0] req_idx;
   logic [TAG_WIDTH-1:0] req_tag_q;
   logic [SET_WIDTH-1:0] sweep_idx_q;
   logic                 sweep_done_q;

   assign req_idx = req_adr_i[TAG_LSB-1:IDX_LSB];

   // Clear sweep, one set per cycle after reset
   always_ff @(posedge clk) begin
      if (rst) begin
         sweep_idx_q  <= '0;
         sweep_done_q <= 1'b0;
      end else if (!sweep_done_q) begin
         sweep_idx_q <= sweep_idx_q + 1'b1;
         // Last set written this cycle
         if (&sweep_idx_q) begin
            sweep_done_q <= 1'b1;
         end
      end
   end

   // Request tag lines up with the RAM output one cycle later
   always_ff @(posedge clk) begin
      req_tag_q <= req_adr_i[ADR_WIDTH-1:TAG_LSB];
   end

   // Write port owned by the sweep until it finishes
   always_comb begin
      if (sweep_done_q) begin
         ram_waddr = wr_adr_i[TAG_LSB-1:IDX_LSB];
         ram_din   = {tag_valid_i, wr_adr_i[ADR_WIDTH-1:TAG_LSB]};
         ram_we    = tag_we_i;
      end else begin
         ram_waddr = sweep_idx_q;
         ram_din   = '0;
         ram_we    = 1'b1;
      end
   end

   dcache_ram #(
      .ADDR_WIDTH(SET_WIDTH),
      .DATA_WIDTH(TAG_WIDTH + 1)
   ) tag_ram_inst (
      .clk    (clk),
      .raddr_i(req_idx),
      .waddr_i(ram_waddr),
      .we_i   (ram_we),
      .din_i  (ram_din),
      .dout_o (ram_dout)
   );

   // Hit needs a valid entry with a matching tag
   assign hit_o        = ram_dout[TAG_WIDTH] && (ram_dout[TAG_WIDTH-1:0] == req_tag_q);
   assign sweep_done_o = sweep_done_q;

endmodule

// File: hdl/dcache_ram.sv
/* Simple dual-port RAM with registered read and write-to-read bypass.
   Holds the tag entries and the cache data words. */
`timescale 1ns/100ps

module dcache_ram #(
   parameter int ADDR_WIDTH = 6,
   parameter int DATA_WIDTH = 32
) (
   input  logic                  clk,
   input  logic [ADDR_WIDTH-1:0] raddr_i,
   input  logic [ADDR_WIDTH-1:0] waddr_i,
   input  logic                  we_i,
   input  logic [DATA_WIDTH-1:0] din_i,
   output logic [DATA_WIDTH-1:0] dout_o
);

   logic [DATA_WIDTH-1:0] mem [0:(1 << ADDR_WIDTH)-1];

   // Write port
   always_ff @(posedge clk) begin
      if (we_i) begin
         mem[waddr_i] <= din_i;
      end
   end

   // Read port, one cycle after the address
   // Same-address write in the same cycle returns the new data
   always_ff @(posedge clk) begin
      if (we_i && (waddr_i == raddr_i)) begin
         dout_o <= din_i;
      end else begin
         dout_o <= mem[raddr_i];
      end
   end

endmodule

// File: hdl/dcache_pkg.sv
/* Shared types for the direct-mapped data cache.
   Imported by the lookup, controller, data path and top level. */
package dcache_pkg;

   // Address and data widths of the load/store unit
   localparam int ADR_WIDTH  = 32;
   localparam int WORD_WIDTH = 32;
   localparam int BSEL_WIDTH = WORD_WIDTH / 8;

   typedef logic [WORD_WIDTH-1:0] word_t;
   typedef logic [ADR_WIDTH-1:0]  adr_t;
   // One bit per byte lane, bit 0 is the low byte
   typedef logic [BSEL_WIDTH-1:0] bsel_t;

   // CPU request, held by the CPU until the ack pulse
   typedef struct packed {
      logic  valid;
      logic  we;
      adr_t  adr;
      word_t dat;
      bsel_t bsel;
   } cpu_req_t;

   // One refill word from the bus
   // Words arrive from the line base upwards, gaps allowed
   typedef struct packed {
      logic  stb;
      word_t dat;
   } refill_t;

   // Controller states
   typedef enum logic [1:0] {
      IDLE,
      LOOKUP,
      REFILL,
      INVALIDATE
   } ctrl_state_e;

endpackage
